// ==== files.f ====
rtl/stream_fifo_pkg.sv
rtl/fifo_sr_core.sv
rtl/fifo_out_reg.sv
rtl/stream_fifo_sr.sv
testbench/tb_traffic.sv
testbench/tb_main.sv

// ==== rtl/fifo_out_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_out_reg
    import stream_fifo_pkg::*;
    (
        input   var logic           clk,
        input   var logic           reset,
        input   var logic           cke,

        input   var stream_beat_t   head,
        output  var logic           pop,

        output  var data_t          m_data,
        output  var logic           m_valid,
        input   var logic           m_ready
    );

    data_t  reg_data;
    logic   reg_valid;
    logic   can_take;

    // register is empty, or its word leaves on this edge
    assign can_take = !reg_valid || m_ready;
    assign pop      = can_take && head.valid;


    always_ff @(posedge clk) begin
        if ( reset ) begin
            reg_valid <= 1'b0;
        end
        else if ( cke ) begin
            if ( pop ) begin
                reg_valid <= 1'b1;
            end
            else if ( m_ready ) begin
                reg_valid <= 1'b0;  // sent, nothing behind it
            end
        end
    end

    // oldest word taken from the core
    always_ff @(posedge clk) begin
        if ( cke && pop ) begin
            reg_data <= head.data;
        end
    end

    assign m_data  = reg_data;
    assign m_valid = reg_valid;


    // stalled word must not move or vanish
    property p_hold_on_stall;
        @(posedge clk) disable iff ( reset )
            (cke && m_valid && !m_ready) |=> (m_valid && $stable(m_data));
    endproperty

    assert property ( p_hold_on_stall )
        else $error("fifo_out_reg: output changed under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/fifo_sr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_sr_core
    import stream_fifo_pkg::*;
    (
        input   var logic           clk,
        input   var logic           reset,
        input   var logic           cke,

        input   var logic           push,
        input   var logic           pop,
        input   var data_t          s_data,

        output  var stream_beat_t   head,
        output  var size_t          count,
        output  var logic           full
    );

    data_t                  mem [DEPTH];    // entry 0 is the newest
    size_t                  count_next;
    logic   [IDX_BITS-1:0]  rd_idx;
    logic                   empty;

    assign empty = (count == '0);
    assign full  = (count == size_t'(DEPTH));

    // read position follows the oldest word
    assign rd_idx = IDX_BITS'(count - 1'b1);


    // occupancy
    always_comb begin
        count_next = count;
        case ( {push, pop} )
        2'b10: begin
            count_next = count + 1'b1;
        end
        2'b01: begin
            count_next = count - 1'b1;
        end
        default: begin
            count_next = count;     // idle, or push and pop together
        end
        endcase
    end

    always_ff @(posedge clk) begin
        if ( reset ) begin
            count <= '0;
        end
        else if ( cke ) begin
            count <= count_next;
        end
    end


    // shift in at entry zero, every word moves up one
    // when full with a pop, the top entry falls out and it is the one being popped
    always_ff @(posedge clk) begin
        if ( cke && push ) begin
            mem[0] <= s_data;
            for ( int i = 1; i < DEPTH; i++ ) begin
                mem[i] <= mem[i-1];
            end
        end
    end


    // head
    always_comb begin
        head.valid = !empty;
        head.data  = mem[rd_idx];
    end


    // pop comes from the output register, push from the top level
    property p_no_overflow;
        @(posedge clk) disable iff ( reset )
            (cke && push && full) |-> pop;
    endproperty

    assert property ( p_no_overflow )
        else $error("fifo_sr_core: push while full without pop");

    property p_no_underflow;
        @(posedge clk) disable iff ( reset )
            (cke && pop) |-> !empty;
    endproperty

    assert property ( p_no_underflow )
        else $error("fifo_sr_core: pop while empty");

endmodule

`default_nettype wire

// ==== rtl/stream_fifo_pkg.sv ====
`default_nettype none

package stream_fifo_pkg;

    // word and store geometry
    localparam int DATA_BITS = 16;
    localparam int DEPTH     = 16;
    localparam int IDX_BITS  = $clog2(DEPTH);
    localparam int SIZE_BITS = 5;   // must reach DEPTH + 1

    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [SIZE_BITS-1:0] size_t;

    // oldest word offered by the core
    typedef struct packed {
        logic   valid;
        data_t  data;
    } stream_beat_t;

    // free space on the input side, words held on the output side
    typedef struct packed {
        size_t  free_size;
        size_t  data_size;
    } fifo_status_t;

endpackage

`default_nettype wire

// ==== rtl/stream_fifo_sr.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_sr
    import stream_fifo_pkg::*;
    (
        input   var logic           clk,
        input   var logic           reset,
        input   var logic           cke,

        input   var data_t          s_data,
        input   var logic           s_valid,
        output  var logic           s_ready,

        output  var data_t          m_data,
        output  var logic           m_valid,
        input   var logic           m_ready,

        output  var fifo_status_t   status
    );

    stream_beat_t   head;
    size_t          count;
    logic           full;
    logic           pop;
    logic           push;

    // a pop frees an entry first, so a full core still takes a word
    assign s_ready = !full || pop;
    assign push    = s_valid && s_ready;

    fifo_sr_core
        u_core
            (
                .clk        (clk        ),
                .reset      (reset      ),
                .cke        (cke        ),
                .push       (push       ),
                .pop        (pop        ),
                .s_data     (s_data     ),
                .head       (head       ),
                .count      (count      ),
                .full       (full       )
            );

    fifo_out_reg
        u_out_reg
            (
                .clk        (clk        ),
                .reset      (reset      ),
                .cke        (cke        ),
                .head       (head       ),
                .pop        (pop        ),
                .m_data     (m_data     ),
                .m_valid    (m_valid    ),
                .m_ready    (m_ready    )
            );

    // output register holds one word beyond the core
    always_comb begin
        status.free_size = size_t'(DEPTH) - count;
        status.data_size = count + size_t'(m_valid);
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the stream FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_main -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_main)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// ==== testbench/tb_main.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_main
    import stream_fifo_pkg::*;
    ();

    localparam int RANDOM_CYCLES = 3000;
    localparam int FILL_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 1000;

    logic           clk;
    logic           reset;
    logic           cke;
    data_t          s_data;
    logic           s_valid;
    logic           s_ready;
    data_t          m_data;
    logic           m_valid;
    logic           m_ready;
    fifo_status_t   status;

    logic           m_ready_mode;
    logic           src_enable;

    data_t          model_q [$];   // words accepted and not yet sent
    int             checks [1:6] = '{0, 0, 0, 0, 0, 0};
    int             errors [1:6] = '{0, 0, 0, 0, 0, 0};
    logic           timed_out;

    // snapshot before a frozen edge
    logic           hold_armed;
    fifo_status_t   hold_status;
    logic           hold_valid;
    data_t          hold_data;

    int             lat_state;
    int             lat_cases;
    data_t          lat_word;

    int             fill_count;
    data_t          first_word;
    int             wait_n;
    int             total_checks;
    int             total_errors;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    stream_fifo_sr dut0 (
        .clk        (clk        ),
        .reset      (reset      ),
        .cke        (cke        ),
        .s_data     (s_data     ),
        .s_valid    (s_valid    ),
        .s_ready    (s_ready    ),
        .m_data     (m_data     ),
        .m_valid    (m_valid    ),
        .m_ready    (m_ready    ),
        .status     (status     )
    );

    tb_traffic u_traffic (
        .clk            (clk            ),
        .reset          (reset          ),
        .s_ready        (s_ready        ),
        .m_ready_mode   (m_ready_mode   ),
        .src_enable     (src_enable     ),
        .s_data         (s_data         ),
        .s_valid        (s_valid        ),
        .m_ready        (m_ready        ),
        .cke            (cke            )
    );

    task automatic check_value(input int test_idx, input string name,
                               input logic [31:0] got, input logic [31:0] expected);
        checks[test_idx]++;
        assert (got == expected) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            errors[test_idx]++;
        end
    endtask

    task automatic check_true(input int test_idx, input logic cond, input string what);
        checks[test_idx]++;
        assert (cond) else begin
            $display("%s", what);
            errors[test_idx]++;
        end
    endtask

    task automatic report_test(input int test_idx, input string name);
        $display("test %0d %s: %0d checks, %0d errors, %s", test_idx, name,
                 checks[test_idx], errors[test_idx],
                 (errors[test_idx] == 0) ? "ok" : "failed");
    endtask

    // values at mid-cycle are the ones the next edge samples
    always @(negedge clk) begin
        if ( reset ) begin
            model_q.delete();
            hold_armed = 1'b0;
            lat_state  = 0;
            lat_cases  = 0;
        end
        else begin
            check_value(5, "status.data_size", 32'(status.data_size), 32'(model_q.size()));
            check_value(5, "status.free_size", 32'(status.free_size),
                        32'(DEPTH - model_q.size() + (m_valid ? 1 : 0)));

            if ( hold_armed ) begin
                check_value(6, "status", 32'(status), 32'(hold_status));
                check_value(6, "m_valid", 32'(m_valid), 32'(hold_valid));
                check_value(6, "m_data", 32'(m_data), 32'(hold_data));
                hold_armed = 1'b0;
            end
            if ( !cke ) begin
                hold_armed  = 1'b1;
                hold_status = status;
                hold_valid  = m_valid;
                hold_data   = m_data;
            end

            case ( lat_state )
            1: begin
                check_value(4, "m_valid", 32'(m_valid), 32'd0);   // too early
                if ( cke ) begin
                    lat_state = 2;
                end
            end
            2: begin
                check_value(4, "m_valid", 32'(m_valid), 32'd1);
                check_value(4, "m_data", 32'(m_data), 32'(lat_word));
                lat_state = 0;
            end
            default: begin
                if ( model_q.size() == 0 && cke && s_valid && s_ready ) begin
                    lat_word  = s_data;
                    lat_state = 1;
                    lat_cases++;
                end
            end
            endcase

            if ( cke && m_valid && m_ready ) begin
                check_true(2, model_q.size() != 0,
                           "scoreboard: DUT sent a word that was never accepted");
                if ( model_q.size() != 0 ) begin
                    check_value(2, "m_data", 32'(m_data), 32'(model_q[0]));
                    void'(model_q.pop_front());
                end
            end
            if ( cke && s_valid && s_ready ) begin
                model_q.push_back(s_data);
            end
        end
    end

    initial begin
        timed_out    = 1'b0;
        reset        = 1'b1;
        m_ready_mode = 1'b0;
        src_enable   = 1'b1;
        repeat ( 3 ) @(posedge clk);
        #1 reset = 1'b0;

        @(negedge clk);
        check_value(1, "m_valid", 32'(m_valid), 32'd0);
        check_value(1, "s_ready", 32'(s_ready), 32'd1);
        check_value(1, "status.data_size", 32'(status.data_size), 32'd0);
        check_value(1, "status.free_size", 32'(status.free_size), 32'(DEPTH));
        report_test(1, "reset state");

        // sink stalled from reset on
        fill_count = 0;
        first_word = '0;
        wait_n     = 0;
        while ( s_ready && wait_n < FILL_TIMEOUT ) begin
            if ( cke && s_valid ) begin
                if ( fill_count == 0 ) begin
                    first_word = s_data;
                end
                fill_count++;
            end
            if ( m_valid ) begin
                check_value(3, "m_data", 32'(m_data), 32'(first_word));
            end
            @(negedge clk);
            wait_n++;
        end
        if ( s_ready ) begin
            $display("fill: s_ready stayed high for %0d cycles with m_ready low", FILL_TIMEOUT);
            timed_out = 1'b1;
        end
        else begin
            check_value(3, "transfers before s_ready low", 32'(fill_count), 32'(DEPTH + 1));
            check_value(3, "status.data_size", 32'(status.data_size), 32'(DEPTH + 1));
            check_value(3, "status.free_size", 32'(status.free_size), 32'd0);
            check_value(3, "m_valid", 32'(m_valid), 32'd1);
            check_value(3, "m_data", 32'(m_data), 32'(first_word));
        end
        report_test(3, "fill under back-pressure");

        if ( !timed_out ) begin
            m_ready_mode = 1'b1;
            repeat ( RANDOM_CYCLES ) @(negedge clk);

            src_enable = 1'b0;      // source stops after its held word
            wait_n     = 0;
            while ( (s_valid || status.data_size != 0) && wait_n < DRAIN_TIMEOUT ) begin
                @(negedge clk);
                wait_n++;
            end
            if ( s_valid || status.data_size != 0 ) begin
                $display("drain: FIFO did not empty within %0d cycles", DRAIN_TIMEOUT);
                timed_out = 1'b1;
            end
            else begin
                @(posedge clk);
                #1;
                check_value(2, "model queue length", 32'(model_q.size()), 32'd0);
            end
            check_true(4, lat_cases != 0, "latency: no push into an empty FIFO was seen");
        end
        report_test(2, "random traffic scoreboard");
        report_test(4, "latency from empty");
        report_test(5, "status counts");
        report_test(6, "clock enable hold");

        total_checks = 0;
        total_errors = 0;
        for ( int i = 1; i <= 6; i++ ) begin
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("total: %0d checks, %0d errors, %0d timeouts", total_checks, total_errors,
                 timed_out ? 1 : 0);
        if ( !timed_out && total_errors == 0 ) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_traffic.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_traffic
    import stream_fifo_pkg::*;
    (
        input   var logic   clk,
        input   var logic   reset,
        input   var logic   s_ready,
        input   var logic   m_ready_mode,   // low holds m_ready low
        input   var logic   src_enable,

        output  var data_t  s_data,
        output  var logic   s_valid,
        output  var logic   m_ready,
        output  var logic   cke
    );

    localparam logic [31:0] LCG_SEED = 32'd18;

    logic [31:0]    rnd;
    logic           fire;
    logic           in_reset;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        rnd      = LCG_SEED;
        s_data   = '0;
        s_valid  = 1'b0;
        m_ready  = 1'b0;
        cke      = 1'b1;
        fire     = 1'b0;
        in_reset = 1'b1;
        forever begin
            @(negedge clk);
            fire     = cke && s_valid && s_ready;   // transfer on the coming edge
            in_reset = reset;                       // settled mid-cycle
            @(posedge clk);
            #1;
            rnd = next_random(rnd);
            if ( in_reset ) begin
                s_data  = '0;
                s_valid = 1'b0;
            end
            else begin
                if ( fire ) begin
                    s_data = s_data + 1'b1;     // counting pattern
                end
                // a held word stays on the port until it is taken
                if ( fire || !s_valid ) begin
                    s_valid = src_enable && rnd[17];
                end
            end
            m_ready = m_ready_mode && (rnd[21:20] != 2'b00);
            cke     = (rnd[26:24] != 3'b000);   // low about one cycle in eight
        end
    end

endmodule

`default_nettype wire
